//--- src.f
+incdir+hw
hw/spmm_pkg.sv
hw/rhs_loader.sv
hw/lhs_tile_ctrl.sv
hw/seg_scan.sv
hw/pe_column.sv
hw/out_stream.sv
hw/spmm_top.sv
sim/spmm_props.sv
sim/spmm_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module spmm_tb -f src.f -o Vspmm_tb

./obj_dir/Vspmm_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

//--- sim/spmm_tb.sv
`include "spmm_config.svh"

module spmm_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N = `SPMM_N;
    localparam int BEATS = `SPMM_N / `SPMM_BEAT_ROWS;
    localparam int NUM_CASES = 6;
    localparam int TIMEOUT = 200;

    // each table entry holds a tile, a B reload flag with its fill seed and a stall rate
    typedef struct packed {
        spmm_pkg::lhs_tile_t tile;
        logic reload;
        logic [15:0] b_seed;
        logic [7:0] stall_pct;
    } case_t;

    logic clock;
    logic reset;
    logic rhs_valid;
    logic rhs_ready;
    spmm_pkg::beat_t rhs_beat;
    logic lhs_valid;
    logic lhs_ready;
    spmm_pkg::lhs_tile_t lhs_tile;
    logic out_valid;
    logic out_ready;
    spmm_pkg::beat_t out_beat;

    case_t cases [NUM_CASES];
    spmm_pkg::mat_t b_mat;
    spmm_pkg::mat_t c_exp;

    spmm_top i_spmm_top (
        .clock     (clock),
        .reset     (reset),
        .rhs_valid (rhs_valid),
        .rhs_ready (rhs_ready),
        .rhs_beat  (rhs_beat),
        .lhs_valid (lhs_valid),
        .lhs_ready (lhs_ready),
        .lhs_tile  (lhs_tile),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_beat  (out_beat)
    );

    always #4 clock = ~clock;

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_beat(input string name, input spmm_pkg::beat_t got,
                              input spmm_pkg::beat_t exp);
        if (got !== exp) begin
            stop_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic add_case(input int idx, input spmm_pkg::ptr_t [N-1:0] ptr,
                            input spmm_pkg::col_idx_t [N-1:0] col,
                            input spmm_pkg::elem_t [N-1:0] data,
                            input logic reload, input int seed, input int stall);
        cases[idx].tile.ptr = ptr;
        cases[idx].tile.col = col;
        cases[idx].tile.data = data;
        cases[idx].reload = reload;
        cases[idx].b_seed = 16'(seed);
        cases[idx].stall_pct = 8'(stall);
    endtask

    function automatic spmm_pkg::beat_t beat_of_rows(input spmm_pkg::mat_t m, input int k);
        for (int j = 0; j < `SPMM_BEAT_ROWS; j++) begin
            beat_of_rows[j] = m[k * `SPMM_BEAT_ROWS + j];
        end
    endfunction

    task automatic fill_b(input int seed);
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                b_mat[r][c] = spmm_pkg::elem_t'(seed * 7 + r * 29 + c * 11 + r * c * 3);
            end
        end
    endtask

    // C[r][c] = sum of data[i] * B[col[i]][c] over the nonzeros of row r
    task automatic model_tile(input spmm_pkg::lhs_tile_t t);
        int start;
        spmm_pkg::elem_t acc;
        for (int r = 0; r < N; r++) begin
            start = (r == 0) ? 0 : int'(t.ptr[r-1]);
            for (int c = 0; c < N; c++) begin
                acc = '0;
                for (int i = start; i < int'(t.ptr[r]); i++) begin
                    acc = acc + t.data[i] * b_mat[t.col[i]][c];
                end
                c_exp[r][c] = acc;
            end
        end
    endtask

    task automatic load_b();
        int waited;
        @(negedge clock);
        for (int k = 0; k < BEATS; k++) begin
            rhs_valid = 1'b1;
            rhs_beat = beat_of_rows(b_mat, k);
            waited = 0;
            while (!rhs_ready) begin
                @(negedge clock);
                waited++;
                if (waited > TIMEOUT) begin
                    stop_run("timeout waiting for rhs_ready");
                end
            end
            @(negedge clock);
            // B only counts as loaded after the final beat
            if (k < BEATS - 1) begin
                check_flag("lhs_ready", lhs_ready, 1'b0);
            end
        end
        rhs_valid = 1'b0;
        check_flag("lhs_ready", lhs_ready, 1'b1);
    endtask

    task automatic send_tile(input spmm_pkg::lhs_tile_t t);
        int waited;
        waited = 0;
        @(negedge clock);
        lhs_valid = 1'b1;
        lhs_tile = t;
        while (!lhs_ready) begin
            @(negedge clock);
            waited++;
            if (waited > TIMEOUT) begin
                stop_run("timeout waiting for lhs_ready");
            end
        end
        @(negedge clock);
        lhs_valid = 1'b0;
        // B is frozen while the tile runs
        check_flag("rhs_ready", rhs_ready, 1'b0);
    endtask

    task automatic receive_out(input int case_idx, input int stall_pct);
        int k;
        int waited;
        k = 0;
        waited = 0;
        while (k < BEATS) begin
            @(negedge clock);
            out_ready = ($urandom_range(99) >= stall_pct);
            if (out_valid && out_ready) begin
                check_beat($sformatf("out_beat[%0d] case %0d", k, case_idx),
                           out_beat, beat_of_rows(c_exp, k));
                k++;
                waited = 0;
            end else begin
                waited++;
                if (waited > TIMEOUT) begin
                    stop_run($sformatf("timeout waiting for output beat %0d", k));
                end
            end
        end
        @(negedge clock);
        out_ready = 1'b0;
        // no beat beyond the last row of C
        check_flag("out_valid", out_valid, 1'b0);
    endtask

    initial begin
        void'($urandom(38580));
        clock = 1'b0;
        reset = 1'b1;
        rhs_valid = 1'b0;
        rhs_beat = '0;
        lhs_valid = 1'b0;
        lhs_tile = '0;
        out_ready = 1'b0;

        // one nonzero per row
        add_case(0, 32'h87654321, {3'd2, 3'd7, 3'd0, 3'd4, 3'd1, 3'd6, 3'd3, 3'd5},
                 64'h0302010504070201, 1'b1, 11, 0);
        // empty rows, including row 0, and three nonzeros past the final pointer
        add_case(1, 32'h55533220, {3'd7, 3'd6, 3'd5, 3'd4, 3'd3, 3'd2, 3'd1, 3'd0},
                 64'hFFEEDD0403020109, 1'b0, 0, 0);
        // all nonzeros in row 3 with large values
        add_case(2, 32'h88888000, {3'd7, 3'd7, 3'd3, 3'd0, 3'd1, 3'd6, 3'd2, 3'd5},
                 64'hF7E9DBCDBFB1A3F5, 1'b1, 97, 30);
        // mixed row lengths
        add_case(3, 32'h88876331, {3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd6, 3'd7, 3'd0},
                 64'h8090A0B0C0D0E0F1, 1'b0, 0, 50);
        add_case(4, 32'h88888642, {3'd0, 3'd3, 3'd6, 3'd1, 3'd4, 3'd7, 3'd2, 3'd5},
                 64'h1122334455667788, 1'b0, 0, 70);
        // new B under the same kind of tile
        add_case(5, 32'h87654321, {3'd2, 3'd7, 3'd0, 3'd4, 3'd1, 3'd6, 3'd3, 3'd5},
                 64'h0302010504070201, 1'b1, 200, 40);

        repeat (8) @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        check_flag("rhs_ready", rhs_ready, 1'b1);
        check_flag("lhs_ready", lhs_ready, 1'b0);
        check_flag("out_valid", out_valid, 1'b0);

        for (int n = 0; n < NUM_CASES; n++) begin
            if (cases[n].reload) begin
                fill_b(int'(cases[n].b_seed));
                load_b();
            end
            model_tile(cases[n].tile);
            send_tile(cases[n].tile);
            receive_out(n, int'(cases[n].stall_pct));
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- sim/spmm_props.sv
module spmm_props (
    input  logic                clock,
    input  logic                reset,
    input  logic                out_valid,
    input  logic                out_ready,
    input  spmm_pkg::beat_t     out_beat,
    input  logic                lhs_ready,
    input  logic                rhs_loaded
);
    timeunit 1ns;
    timeprecision 100ps;

    // held beat under back-pressure
    a_beat_stable: assert property (@(posedge clock) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_beat))
        else $error("output beat changed while stalled");

    a_valid_reset: assert property (@(posedge clock) reset |-> !out_valid)
        else $error("out_valid high during reset");

    a_lhs_loaded: assert property (@(posedge clock) disable iff (reset)
        lhs_ready |-> rhs_loaded)
        else $error("lhs_ready high before B is loaded");

endmodule

bind spmm_top spmm_props i_spmm_props (
    .clock      (clock),
    .reset      (reset),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_beat   (out_beat),
    .lhs_ready  (lhs_ready),
    .rhs_loaded (rhs_loaded)
);

//--- hw/spmm_top.sv
`include "spmm_config.svh"

module spmm_top (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    rhs_valid,
    output logic                    rhs_ready,
    input  spmm_pkg::beat_t         rhs_beat,
    input  logic                    lhs_valid,
    output logic                    lhs_ready,
    input  spmm_pkg::lhs_tile_t     lhs_tile,
    output logic                    out_valid,
    input  logic                    out_ready,
    output spmm_pkg::beat_t         out_beat
);
    spmm_pkg::mat_t rhs_matrix;
    logic rhs_loaded;
    logic tile_busy;
    spmm_pkg::lhs_tile_t tile;
    spmm_pkg::seg_ctrl_t seg_ctrl;
    logic capture;
    // indexed by column
    spmm_pkg::mat_t col_results;
    logic out_busy;

    rhs_loader i_rhs_loader (
        .clock      (clock),
        .reset      (reset),
        .rhs_valid  (rhs_valid),
        .rhs_ready  (rhs_ready),
        .rhs_beat   (rhs_beat),
        .tile_busy  (tile_busy),
        .rhs_matrix (rhs_matrix),
        .rhs_loaded (rhs_loaded)
    );

    lhs_tile_ctrl i_lhs_tile_ctrl (
        .clock      (clock),
        .reset      (reset),
        .lhs_valid  (lhs_valid),
        .lhs_ready  (lhs_ready),
        .lhs_tile   (lhs_tile),
        .rhs_loaded (rhs_loaded),
        .out_busy   (out_busy),
        .tile       (tile),
        .seg_ctrl   (seg_ctrl),
        .tile_busy  (tile_busy),
        .capture    (capture)
    );

    for (genvar c = 0; c < `SPMM_N; c++) begin : g_col
        spmm_pkg::row_t rhs_col;

        // column c of B
        for (genvar r = 0; r < `SPMM_N; r++) begin : g_row
            assign rhs_col[r] = rhs_matrix[r][c];
        end

        pe_column i_pe_column (
            .clock      (clock),
            .reset      (reset),
            .tile       (tile),
            .seg_ctrl   (seg_ctrl),
            .rhs_col    (rhs_col),
            .col_result (col_results[c])
        );
    end

    out_stream i_out_stream (
        .clock       (clock),
        .reset       (reset),
        .capture     (capture),
        .col_results (col_results),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_beat    (out_beat),
        .out_busy    (out_busy)
    );

endmodule

//--- hw/out_stream.sv
`include "spmm_config.svh"

module out_stream (
    input  logic                clock,
    input  logic                reset,
    input  logic                capture,
    input  spmm_pkg::mat_t      col_results,
    output logic                out_valid,
    input  logic                out_ready,
    output spmm_pkg::beat_t     out_beat,
    output logic                out_busy
);
    localparam int BEATS = `SPMM_N / `SPMM_BEAT_ROWS;
    localparam int CNT_W = (BEATS > 1) ? $clog2(BEATS) : 1;

    spmm_pkg::out_state_e state;
    logic [CNT_W-1:0] beat_cnt;
    // row major result C
    spmm_pkg::mat_t c_mat;
    logic accept;

    assign out_busy = (state == spmm_pkg::OUT_SEND);
    assign out_valid = (state == spmm_pkg::OUT_SEND);
    assign accept = out_valid && out_ready;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= spmm_pkg::OUT_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                spmm_pkg::OUT_IDLE: begin
                    if (capture) begin
                        state <= spmm_pkg::OUT_SEND;
                        beat_cnt <= '0;
                    end
                end
                spmm_pkg::OUT_SEND: begin
                    if (accept) begin
                        if (beat_cnt == CNT_W'(BEATS - 1)) begin
                            state <= spmm_pkg::OUT_IDLE;
                            beat_cnt <= '0;
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                    end
                end
                default: state <= spmm_pkg::OUT_IDLE;
            endcase
        end
    end

    // transpose column results into rows
    always_ff @(posedge clock) begin
        if (capture) begin
            for (int r = 0; r < `SPMM_N; r++) begin
                for (int c = 0; c < `SPMM_N; c++) begin
                    c_mat[r][c] <= col_results[c][r];
                end
            end
        end
    end

    // beat held by the counter until accepted
    always_comb begin
        for (int k = 0; k < `SPMM_BEAT_ROWS; k++) begin
            out_beat[k] = c_mat[int'(beat_cnt) * `SPMM_BEAT_ROWS + k];
        end
    end

endmodule

//--- hw/pe_column.sv
`include "spmm_config.svh"

module pe_column (
    input  logic                    clock,
    input  logic                    reset,
    input  spmm_pkg::lhs_tile_t     tile,
    input  spmm_pkg::seg_ctrl_t     seg_ctrl,
    input  spmm_pkg::row_t          rhs_col,
    output spmm_pkg::row_t          col_result
);
    spmm_pkg::row_t products;
    spmm_pkg::row_t sums;

    // one multiplier per nonzero, product wraps at element width
    always_ff @(posedge clock) begin
        for (int i = 0; i < `SPMM_N; i++) begin
            products[i] <= tile.data[i] * rhs_col[tile.col[i]];
        end
    end

    seg_scan i_seg_scan (
        .clock    (clock),
        .reset    (reset),
        .products (products),
        .seg_last (seg_ctrl.seg_last),
        .sums     (sums)
    );

    // each row reads the running sum at its last nonzero
    always_comb begin
        for (int r = 0; r < `SPMM_N; r++) begin
            if (seg_ctrl.row_empty[r]) begin
                col_result[r] = '0;
            end else begin
                col_result[r] = sums[seg_ctrl.row_last[r]];
            end
        end
    end

endmodule

//--- hw/seg_scan.sv
`include "spmm_config.svh"

module seg_scan (
    input  logic                    clock,
    input  logic                    reset,
    input  spmm_pkg::row_t          products,
    input  logic [`SPMM_N-1:0]      seg_last,
    output spmm_pkg::row_t          sums
);
    localparam int LEVELS = `SPMM_LG_N;

    spmm_pkg::row_t lvl_d [1:LEVELS];
    // head flags, only needed by levels that feed another level
    logic [`SPMM_N-1:0] lvl_h [1:LEVELS-1];

    for (genvar d = 0; d < LEVELS; d++) begin : g_level
        localparam int STRIDE = 1 << d;
        spmm_pkg::row_t d_in;
        logic [`SPMM_N-1:0] h_in;

        if (d == 0) begin : g_first
            assign d_in = products;
            // a segment opens after each segment end, and at element 0
            assign h_in = {seg_last[`SPMM_N-2:0], 1'b1};
        end else begin : g_next
            assign d_in = lvl_d[d];
            assign h_in = lvl_h[d];
        end

        always_ff @(posedge clock) begin
            for (int i = 0; i < `SPMM_N; i++) begin
                if (i >= STRIDE && !h_in[i]) begin
                    lvl_d[d+1][i] <= d_in[i] + d_in[i - STRIDE];
                end else begin
                    lvl_d[d+1][i] <= d_in[i];
                end
            end
        end

        if (d < LEVELS - 1) begin : g_flag
            always_ff @(posedge clock or posedge reset) begin
                int left;
                if (reset) begin
                    lvl_h[d+1] <= '0;
                end else begin
                    for (int i = 0; i < `SPMM_N; i++) begin
                        left = (i >= STRIDE) ? i - STRIDE : i;
                        lvl_h[d+1][i] <= h_in[i] | h_in[left];
                    end
                end
            end
        end
    end

    assign sums = lvl_d[LEVELS];

endmodule

//--- hw/lhs_tile_ctrl.sv
`include "spmm_config.svh"

module lhs_tile_ctrl (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    lhs_valid,
    output logic                    lhs_ready,
    input  spmm_pkg::lhs_tile_t     lhs_tile,
    input  logic                    rhs_loaded,
    input  logic                    out_busy,
    output spmm_pkg::lhs_tile_t     tile,
    output spmm_pkg::seg_ctrl_t     seg_ctrl,
    output logic                    tile_busy,
    output logic                    capture
);
    localparam int LAT_W = $clog2(`SPMM_LG_N + 2);

    spmm_pkg::tile_state_e state;
    logic [LAT_W-1:0] lat_cnt;
    spmm_pkg::seg_ctrl_t seg_dec;
    logic accept;

    assign lhs_ready = rhs_loaded && (state == spmm_pkg::TILE_IDLE) && !out_busy;
    assign tile_busy = (state == spmm_pkg::TILE_RUN);
    assign accept = lhs_valid && lhs_ready;

    // pointers to segment ends; nonzeros past the final pointer stay unflagged
    always_comb begin
        spmm_pkg::ptr_t prev;
        spmm_pkg::ptr_t last_nz;
        seg_dec = '0;
        prev = '0;
        for (int r = 0; r < `SPMM_N; r++) begin
            last_nz = lhs_tile.ptr[r] - 1'b1;
            if (lhs_tile.ptr[r] == prev) begin
                seg_dec.row_empty[r] = 1'b1;
            end else begin
                seg_dec.row_last[r] = last_nz[`SPMM_LG_N-1:0];
                seg_dec.seg_last[last_nz[`SPMM_LG_N-1:0]] = 1'b1;
            end
            prev = lhs_tile.ptr[r];
        end
    end

    // one multiplier cycle plus LG_N scan levels, then one cycle for capture
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= spmm_pkg::TILE_IDLE;
            lat_cnt <= '0;
            capture <= 1'b0;
        end else begin
            capture <= 1'b0;
            case (state)
                spmm_pkg::TILE_IDLE: begin
                    if (accept) begin
                        state <= spmm_pkg::TILE_RUN;
                        lat_cnt <= '0;
                    end
                end
                spmm_pkg::TILE_RUN: begin
                    lat_cnt <= lat_cnt + 1'b1;
                    if (lat_cnt == LAT_W'(`SPMM_LG_N)) begin
                        capture <= 1'b1;
                    end
                    // stay busy through capture so no tile slips in before out_busy
                    if (lat_cnt == LAT_W'(`SPMM_LG_N + 1)) begin
                        state <= spmm_pkg::TILE_IDLE;
                    end
                end
                default: state <= spmm_pkg::TILE_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            tile <= lhs_tile;
            seg_ctrl <= seg_dec;
        end
    end

endmodule

//--- hw/rhs_loader.sv
`include "spmm_config.svh"

module rhs_loader (
    input  logic                clock,
    input  logic                reset,
    input  logic                rhs_valid,
    output logic                rhs_ready,
    input  spmm_pkg::beat_t     rhs_beat,
    input  logic                tile_busy,
    output spmm_pkg::mat_t      rhs_matrix,
    output logic                rhs_loaded
);
    localparam int BEATS = `SPMM_N / `SPMM_BEAT_ROWS;
    localparam int CNT_W = (BEATS > 1) ? $clog2(BEATS) : 1;

    spmm_pkg::rhs_state_e state;
    logic [CNT_W-1:0] beat_cnt;
    logic accept;
    logic last_beat;

    // B must not change under a running tile
    assign rhs_ready = !tile_busy;
    assign accept = rhs_valid && rhs_ready;
    assign last_beat = (beat_cnt == CNT_W'(BEATS - 1));

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= spmm_pkg::RHS_IDLE;
            beat_cnt <= '0;
            rhs_loaded <= 1'b0;
        end else if (accept) begin
            // first beat of a new load invalidates the old B
            if (state == spmm_pkg::RHS_IDLE) begin
                rhs_loaded <= 1'b0;
            end
            if (last_beat) begin
                state <= spmm_pkg::RHS_IDLE;
                beat_cnt <= '0;
                rhs_loaded <= 1'b1;
            end else begin
                state <= spmm_pkg::RHS_LOAD;
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // held copy of B, four rows per beat
    always_ff @(posedge clock) begin
        if (accept) begin
            for (int k = 0; k < `SPMM_BEAT_ROWS; k++) begin
                rhs_matrix[int'(beat_cnt) * `SPMM_BEAT_ROWS + k] <= rhs_beat[k];
            end
        end
    end

endmodule

//--- hw/spmm_pkg.sv
`include "spmm_config.svh"

package spmm_pkg;

    typedef logic [`SPMM_W-1:0] elem_t;
    typedef elem_t [`SPMM_N-1:0] row_t;
    // index r is row r
    typedef row_t [`SPMM_N-1:0] mat_t;
    typedef row_t [`SPMM_BEAT_ROWS-1:0] beat_t;

    // row end pointer, 0 to N
    typedef logic [`SPMM_LG_N:0] ptr_t;
    typedef logic [`SPMM_LG_N-1:0] col_idx_t;

    typedef struct packed {
        ptr_t [`SPMM_N-1:0] ptr;
        col_idx_t [`SPMM_N-1:0] col;
        elem_t [`SPMM_N-1:0] data;
    } lhs_tile_t;

    // decoded segment layout of one tile
    typedef struct packed {
        logic [`SPMM_N-1:0] seg_last;
        col_idx_t [`SPMM_N-1:0] row_last;
        logic [`SPMM_N-1:0] row_empty;
    } seg_ctrl_t;

    typedef enum logic {RHS_IDLE, RHS_LOAD} rhs_state_e;
    typedef enum logic {TILE_IDLE, TILE_RUN} tile_state_e;
    typedef enum logic {OUT_IDLE, OUT_SEND} out_state_e;

endpackage

//--- hw/spmm_config.svh
`ifndef SPMM_CONFIG_SVH
`define SPMM_CONFIG_SVH

// matrix size, also the nonzero count of one tile
// must be a power of two and a multiple of four
`define SPMM_N 8

// log2 of SPMM_N, kept in step by hand
`define SPMM_LG_N 3

// element width, all arithmetic wraps here
`define SPMM_W 8

// rows carried by one stream beat
`define SPMM_BEAT_ROWS 4

`endif
